/* rtl/cpx_isa_pkg.sv */
`default_nettype none

package cpx_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [4:0]  reg_addr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // r-type field layout of an instruction word
    typedef struct packed {
        funct7_t   funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        funct3_t   funct3;
        reg_addr_t rd;
        opcode_t   opcode;
    } instr_fields_t;

    // custom-0 major opcode
    localparam opcode_t OPCODE_CPX = 7'b0001011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_MINU    = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL     = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // only bit 30 of the word selects the alternate op
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MINU,
        OP_ILLEGAL
    } cpx_op_e;

endpackage

`default_nettype wire

/* rtl/cpx_bus_pkg.sv */
`default_nettype none

package cpx_bus_pkg;

    import cpx_isa_pkg::*;

    localparam int ID_W = 3;

    typedef logic [ID_W-1:0] id_t;

    // number of distinct transaction ids
    localparam int ID_COUNT = 1 << ID_W;

    typedef struct packed {
        id_t       id;
        instr_t    instr;
        reg_data_t rs1;
        reg_data_t rs2;
    } issue_req_t;

    typedef struct packed {
        logic accept;
    } issue_rsp_t;

    typedef struct packed {
        id_t  id;
        logic kill;
    } commit_t;

    typedef struct packed {
        id_t       id;
        reg_data_t data;
        reg_addr_t rd;
        logic      we;
        logic      err;
    } result_t;

    typedef struct packed {
        id_t    id;
        instr_t instr;
    } dec_req_t;

    typedef struct packed {
        id_t       id;
        cpx_op_e   op;
        reg_addr_t rd;
        logic      illegal;
    } dec_rsp_t;

    typedef struct packed {
        id_t       id;
        cpx_op_e   op;
        reg_addr_t rd;
        reg_data_t rs1;
        reg_data_t rs2;
    } exe_req_t;

    typedef struct packed {
        id_t       id;
        reg_addr_t rd;
        reg_data_t data;
        logic      we;
        logic      err;
    } exe_rsp_t;

endpackage

`default_nettype wire

/* rtl/cpx_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_decoder
    import cpx_bus_pkg::*;
    import cpx_isa_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,

    input  wire dec_req_t dec_req_i,
    input  wire logic     dec_req_valid_i,
    output logic          dec_req_ready_o,

    output dec_rsp_t      dec_rsp_o,
    output logic          dec_rsp_valid_o,
    input  wire logic     dec_rsp_ready_i
);

    dec_rsp_t rsp_d;
    dec_rsp_t rsp_q;
    logic     full_q;

    always_comb begin
        instr_fields_t f;

        f = instr_fields_t'(dec_req_i.instr);
        rsp_d.id = dec_req_i.id;
        rsp_d.rd = f.rd;
        rsp_d.op = OP_ILLEGAL;

        if (f.funct7 == F7_BASE) begin
            case (f.funct3)
                F3_ADD_SUB: rsp_d.op = OP_ADD;
                F3_SLL:     rsp_d.op = OP_SLL;
                F3_MINU:    rsp_d.op = OP_MINU;
                F3_XOR:     rsp_d.op = OP_XOR;
                F3_SRL:     rsp_d.op = OP_SRL;
                F3_OR:      rsp_d.op = OP_OR;
                F3_AND:     rsp_d.op = OP_AND;
                default:    rsp_d.op = OP_ILLEGAL;
            endcase
        end else if (f.funct7 == F7_ALT && f.funct3 == F3_ADD_SUB) begin
            rsp_d.op = OP_SUB;
        end

        rsp_d.illegal = (rsp_d.op == OP_ILLEGAL);
    end

    // one item in flight, no new request while the response waits
    assign dec_req_ready_o = !full_q;
    assign dec_rsp_valid_o = full_q;
    assign dec_rsp_o       = rsp_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (dec_req_valid_i && dec_req_ready_o) begin
            full_q <= 1'b1;
        end else if (dec_rsp_valid_o && dec_rsp_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_req_valid_i && dec_req_ready_o) begin
            rsp_q <= rsp_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpx_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_exec_unit
    import cpx_bus_pkg::*;
    import cpx_isa_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,

    input  wire exe_req_t exe_req_i,
    input  wire logic     exe_req_valid_i,
    output logic          exe_req_ready_o,

    output exe_rsp_t      exe_rsp_o,
    output logic          exe_rsp_valid_o,
    input  wire logic     exe_rsp_ready_i
);

    exe_rsp_t  rsp_d;
    exe_rsp_t  rsp_q;
    logic      full_q;
    reg_data_t a;
    reg_data_t b;
    logic [4:0] shamt;

    assign a     = exe_req_i.rs1;
    assign b     = exe_req_i.rs2;
    // shift amount from the low bits of rs2
    assign shamt = exe_req_i.rs2[4:0];

    always_comb begin
        rsp_d.id   = exe_req_i.id;
        rsp_d.rd   = exe_req_i.rd;
        rsp_d.data = '0;
        rsp_d.we   = (exe_req_i.rd != '0);
        rsp_d.err  = 1'b0;

        case (exe_req_i.op)
            OP_ADD:  rsp_d.data = a + b;
            OP_SUB:  rsp_d.data = a - b;
            OP_AND:  rsp_d.data = a & b;
            OP_OR:   rsp_d.data = a | b;
            OP_XOR:  rsp_d.data = a ^ b;
            OP_SLL:  rsp_d.data = a << shamt;
            OP_SRL:  rsp_d.data = a >> shamt;
            OP_MINU: rsp_d.data = (a < b) ? a : b;
            default: begin
                // illegal op, nothing written back
                rsp_d.data = '0;
                rsp_d.we   = 1'b0;
                rsp_d.err  = 1'b1;
            end
        endcase
    end

    assign exe_req_ready_o = !full_q;
    assign exe_rsp_valid_o = full_q;
    assign exe_rsp_o       = rsp_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (exe_req_valid_i && exe_req_ready_o) begin
            full_q <= 1'b1;
        end else if (exe_rsp_valid_o && exe_rsp_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_req_valid_i && exe_req_ready_o) begin
            rsp_q <= rsp_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpx_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_bridge
    import cpx_bus_pkg::*;
    import cpx_isa_pkg::*;
#(
    parameter int SB_DEPTH = ID_COUNT
) (
    input  wire logic       clk_i,
    input  wire logic       rst_i,

    input  wire logic       issue_valid_i,
    input  wire issue_req_t issue_req_i,
    output logic            issue_ready_o,
    output issue_rsp_t      issue_rsp_o,

    input  wire logic       commit_valid_i,
    input  wire commit_t    commit_i,

    output logic            result_valid_o,
    output result_t         result_o,
    input  wire logic       result_ready_i,

    output dec_req_t        dec_req_o,
    output logic            dec_req_valid_o,
    input  wire logic       dec_req_ready_i,
    input  wire dec_rsp_t   dec_rsp_i,
    input  wire logic       dec_rsp_valid_i,
    output logic            dec_rsp_ready_o,

    output exe_req_t        exe_req_o,
    output logic            exe_req_valid_o,
    input  wire logic       exe_req_ready_i,
    input  wire exe_rsp_t   exe_rsp_i,
    input  wire logic       exe_rsp_valid_i,
    output logic            exe_rsp_ready_o
);

    typedef struct packed {
        instr_t    instr;
        reg_data_t rs1;
        reg_data_t rs2;
        cpx_op_e   op;
        logic      illegal;
        reg_addr_t rd;
        reg_data_t data;
        logic      we;
        logic      err;
        logic      issue_done;
        logic      commit_done;
        logic      dec_req_done;
        logic      dec_rsp_done;
        logic      exe_req_done;
        logic      exe_rsp_done;
        logic      result_done;
    } sb_entry_t;

    sb_entry_t [SB_DEPTH-1:0] sb_d;
    sb_entry_t [SB_DEPTH-1:0] sb_q;

    // result offered but not taken, keep it until it transfers
    logic lock_d;
    logic lock_q;
    id_t  lock_id_d;
    id_t  lock_id_q;

    function automatic logic in_range(input id_t id);
        return int'(id) < SB_DEPTH;
    endfunction

    // lowest set bit wins
    function automatic logic pick_lowest(input logic [SB_DEPTH-1:0] mask, output id_t sel);
        logic found;
        found = 1'b0;
        sel   = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (mask[i]) begin
                found = 1'b1;
                sel   = id_t'(i);
            end
        end
        return found;
    endfunction

    always_comb begin
        id_t                 id;
        logic [SB_DEPTH-1:0] mask;
        logic                found;
        logic                accept;
        instr_fields_t       fields;

        issue_ready_o   = 1'b0;
        issue_rsp_o     = '0;
        result_valid_o  = 1'b0;
        result_o        = '0;
        dec_req_o       = '0;
        dec_req_valid_o = 1'b0;
        dec_rsp_ready_o = 1'b0;
        exe_req_o       = '0;
        exe_req_valid_o = 1'b0;
        exe_rsp_ready_o = 1'b0;
        lock_d          = 1'b0;
        lock_id_d       = lock_id_q;
        sb_d            = sb_q;

        // issue, refused instructions leave the entry free
        id     = issue_req_i.id;
        fields = instr_fields_t'(issue_req_i.instr);
        accept = (fields.opcode == OPCODE_CPX);
        if (issue_valid_i && in_range(id)) begin
            issue_ready_o = !sb_d[id].issue_done;
        end
        if (issue_valid_i && issue_ready_o) begin
            issue_rsp_o.accept = accept;
            if (accept) begin
                sb_d[id].instr      = issue_req_i.instr;
                sb_d[id].rs1        = issue_req_i.rs1;
                sb_d[id].rs2        = issue_req_i.rs2;
                sb_d[id].issue_done = 1'b1;
            end
        end

        // commit
        id = commit_i.id;
        if (commit_valid_i && in_range(id) && sb_d[id].issue_done) begin
            if (commit_i.kill) begin
                sb_d[id] = '0;
            end else begin
                sb_d[id].commit_done = 1'b1;
            end
        end

        // decode request
        for (int i = 0; i < SB_DEPTH; i++) begin
            mask[i] = sb_d[i].commit_done && !sb_d[i].dec_req_done;
        end
        found = pick_lowest(mask, id);
        if (found) begin
            dec_req_o.id    = id;
            dec_req_o.instr = sb_d[id].instr;
            dec_req_valid_o = 1'b1;
            if (dec_req_ready_i) begin
                sb_d[id].dec_req_done = 1'b1;
            end
        end

        // decode response
        id = dec_rsp_i.id;
        if (dec_rsp_valid_i && in_range(id)) begin
            dec_rsp_ready_o = !sb_d[id].dec_rsp_done;
        end
        if (dec_rsp_valid_i && dec_rsp_ready_o) begin
            sb_d[id].op           = dec_rsp_i.op;
            sb_d[id].rd           = dec_rsp_i.rd;
            sb_d[id].illegal      = dec_rsp_i.illegal;
            sb_d[id].dec_rsp_done = 1'b1;
        end

        // execute request
        for (int i = 0; i < SB_DEPTH; i++) begin
            mask[i] = sb_d[i].dec_rsp_done && !sb_d[i].exe_req_done;
        end
        found = pick_lowest(mask, id);
        if (found) begin
            exe_req_o.id    = id;
            exe_req_o.op    = sb_d[id].illegal ? OP_ILLEGAL : sb_d[id].op;
            exe_req_o.rd    = sb_d[id].rd;
            exe_req_o.rs1   = sb_d[id].rs1;
            exe_req_o.rs2   = sb_d[id].rs2;
            exe_req_valid_o = 1'b1;
            if (exe_req_ready_i) begin
                sb_d[id].exe_req_done = 1'b1;
            end
        end

        // execute response
        id = exe_rsp_i.id;
        if (exe_rsp_valid_i && in_range(id)) begin
            exe_rsp_ready_o = !sb_d[id].exe_rsp_done;
        end
        if (exe_rsp_valid_i && exe_rsp_ready_o) begin
            sb_d[id].rd           = exe_rsp_i.rd;
            sb_d[id].data         = exe_rsp_i.data;
            sb_d[id].we           = exe_rsp_i.we;
            sb_d[id].err          = exe_rsp_i.err;
            sb_d[id].exe_rsp_done = 1'b1;
        end

        // result, a locked id has priority over a lower newcomer
        for (int i = 0; i < SB_DEPTH; i++) begin
            mask[i] = sb_d[i].exe_rsp_done && !sb_d[i].result_done;
        end
        if (lock_q) begin
            found = 1'b1;
            id    = lock_id_q;
        end else begin
            found = pick_lowest(mask, id);
        end
        if (found) begin
            result_o.id    = id;
            result_o.data  = sb_d[id].data;
            result_o.rd    = sb_d[id].rd;
            result_o.we    = sb_d[id].we;
            result_o.err   = sb_d[id].err;
            result_valid_o = 1'b1;
            if (result_ready_i) begin
                sb_d[id].result_done = 1'b1;
            end else begin
                lock_d    = 1'b1;
                lock_id_d = id;
            end
        end

        // retire, entry is free from the next cycle on
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (sb_d[i].issue_done && sb_d[i].commit_done &&
                sb_d[i].dec_req_done && sb_d[i].dec_rsp_done &&
                sb_d[i].exe_req_done && sb_d[i].exe_rsp_done &&
                sb_d[i].result_done) begin
                sb_d[i] = '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sb_q      <= '0;
            lock_q    <= 1'b0;
            lock_id_q <= '0;
        end else begin
            sb_q      <= sb_d;
            lock_q    <= lock_d;
            lock_id_q <= lock_id_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_top
    import cpx_bus_pkg::*;
#(
    parameter int SB_DEPTH = ID_COUNT
) (
    input  wire logic       clk_i,
    input  wire logic       rst_i,

    input  wire logic       issue_valid_i,
    input  wire issue_req_t issue_req_i,
    output logic            issue_ready_o,
    output issue_rsp_t      issue_rsp_o,

    input  wire logic       commit_valid_i,
    input  wire commit_t    commit_i,

    output logic            result_valid_o,
    output result_t         result_o,
    input  wire logic       result_ready_i
);

    // bridge to decoder
    dec_req_t dec_req;
    logic     dec_req_valid;
    logic     dec_req_ready;
    dec_rsp_t dec_rsp;
    logic     dec_rsp_valid;
    logic     dec_rsp_ready;

    // bridge to execution unit
    exe_req_t exe_req;
    logic     exe_req_valid;
    logic     exe_req_ready;
    exe_rsp_t exe_rsp;
    logic     exe_rsp_valid;
    logic     exe_rsp_ready;

    cpx_bridge #(
        .SB_DEPTH(SB_DEPTH)
    ) bridge_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .issue_valid_i   (issue_valid_i),
        .issue_req_i     (issue_req_i),
        .issue_ready_o   (issue_ready_o),
        .issue_rsp_o     (issue_rsp_o),
        .commit_valid_i  (commit_valid_i),
        .commit_i        (commit_i),
        .result_valid_o  (result_valid_o),
        .result_o        (result_o),
        .result_ready_i  (result_ready_i),
        .dec_req_o       (dec_req),
        .dec_req_valid_o (dec_req_valid),
        .dec_req_ready_i (dec_req_ready),
        .dec_rsp_i       (dec_rsp),
        .dec_rsp_valid_i (dec_rsp_valid),
        .dec_rsp_ready_o (dec_rsp_ready),
        .exe_req_o       (exe_req),
        .exe_req_valid_o (exe_req_valid),
        .exe_req_ready_i (exe_req_ready),
        .exe_rsp_i       (exe_rsp),
        .exe_rsp_valid_i (exe_rsp_valid),
        .exe_rsp_ready_o (exe_rsp_ready)
    );

    cpx_decoder decoder_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .dec_req_i       (dec_req),
        .dec_req_valid_i (dec_req_valid),
        .dec_req_ready_o (dec_req_ready),
        .dec_rsp_o       (dec_rsp),
        .dec_rsp_valid_o (dec_rsp_valid),
        .dec_rsp_ready_i (dec_rsp_ready)
    );

    cpx_exec_unit exec_unit_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .exe_req_i       (exe_req),
        .exe_req_valid_i (exe_req_valid),
        .exe_req_ready_o (exe_req_ready),
        .exe_rsp_o       (exe_rsp),
        .exe_rsp_valid_o (exe_rsp_valid),
        .exe_rsp_ready_i (exe_rsp_ready)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* verification/cpx_bridge_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_bridge_props
    import cpx_bus_pkg::*;
(
    input wire logic       clk_i,
    input wire logic       rst_i,
    input wire logic       issue_valid_i,
    input wire issue_req_t issue_req_i,
    input wire logic       issue_ready_o,
    input wire logic       dec_req_valid_o,
    input wire logic       exe_req_valid_o,
    input wire logic       result_valid_o,
    input wire logic       result_ready_i,
    input wire result_t    result_o
);

    // state is cleared from the second reset cycle on
    a_no_valid_in_reset: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> !result_valid_o && !dec_req_valid_o && !exe_req_valid_o)
        else $error("valid output high while reset is applied");

    a_result_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
        else $error("result dropped or changed before it was taken");

    // an id whose result is still offered cannot issue again
    a_issue_ready_free_id: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_ready_o |-> issue_valid_i &&
            !(result_valid_o && result_o.id == issue_req_i.id))
        else $error("issue ready raised without valid or for an id with a pending result");

endmodule

`default_nettype wire

/* verification/tb_cpx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpx_top
    import cpx_bus_pkg::*;
    import cpx_isa_pkg::*;
;

    localparam int SB_DEPTH     = 8;
    localparam int WORDS_PER    = 9;
    localparam int MAX_VECTORS  = 64;
    localparam int SAMPLE_DELAY = 10;

    logic       clk_i;
    logic       rst_i;
    logic       issue_valid_i;
    issue_req_t issue_req_i;
    logic       issue_ready_o;
    issue_rsp_t issue_rsp_o;
    logic       commit_valid_i;
    commit_t    commit_i;
    logic       result_valid_o;
    result_t    result_o;
    logic       result_ready_i;

    logic [31:0] vec_mem [0:WORDS_PER*MAX_VECTORS-1];

    // expected scoreboard state per id
    logic [ID_COUNT-1:0] busy;
    reg_data_t           exp_data [ID_COUNT];
    reg_addr_t           exp_rd   [ID_COUNT];
    logic                exp_we   [ID_COUNT];
    logic                exp_err  [ID_COUNT];

    int num_vectors;
    int cycle_limit;
    int cycles;
    int checks;
    int errors;
    int results;
    int busy_refusals;

    tb_clock #(
        .PERIOD_NS(100)
    ) clock_i (
        .clk_o(clk_i)
    );

    cpx_top #(
        .SB_DEPTH(SB_DEPTH)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_req_i    (issue_req_i),
        .issue_ready_o  (issue_ready_o),
        .issue_rsp_o    (issue_rsp_o),
        .commit_valid_i (commit_valid_i),
        .commit_i       (commit_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_ready_i (result_ready_i)
    );

    bind cpx_bridge cpx_bridge_props props_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .issue_valid_i   (issue_valid_i),
        .issue_req_i     (issue_req_i),
        .issue_ready_o   (issue_ready_o),
        .dec_req_valid_o (dec_req_valid_o),
        .exe_req_valid_o (exe_req_valid_o),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_o        (result_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at time %0d ns: %s mismatch, got %h expected %h",
                     $time, what, got, expected);
        end
    endtask

    task automatic check_result(input result_t res);
        id_t id;
        id = res.id;
        results++;
        check_value(busy[id], 1'b1, $sformatf("outstanding entry for result id %0d", id));
        check_value(res.data, exp_data[id], $sformatf("result data of id %0d", id));
        check_value(res.rd, exp_rd[id], $sformatf("result rd of id %0d", id));
        check_value(res.we, exp_we[id], $sformatf("result we of id %0d", id));
        check_value(res.err, exp_err[id], $sformatf("result err of id %0d", id));
        busy[id] = 1'b0;
    endtask

    // issue one vector and commit or kill it when accepted
    task automatic run_vector(input int v);
        int   base;
        id_t  id;
        logic kill;
        logic ready;
        logic accepted;
        base = v * WORDS_PER;
        id   = id_t'(vec_mem[base]);
        kill = vec_mem[base+4][0];

        @(negedge clk_i);
        issue_valid_i     = 1'b1;
        issue_req_i.id    = id;
        issue_req_i.instr = vec_mem[base+1];
        issue_req_i.rs1   = vec_mem[base+2];
        issue_req_i.rs2   = vec_mem[base+3];
        ready = 1'b0;
        while (!ready) begin
            #(SAMPLE_DELAY);
            ready = issue_ready_o;
            check_value(ready, !busy[id], $sformatf("issue_ready_o for id %0d", id));
            if (!ready) begin
                busy_refusals++;
                @(negedge clk_i);
            end
        end
        check_value(issue_rsp_o.accept, vec_mem[base+5][0],
                    $sformatf("accept of vector %0d", v));
        accepted = issue_rsp_o.accept;

        @(posedge clk_i);
        if (accepted) begin
            busy[id]     = 1'b1;
            // rd field sits in bits 11:7 of the word
            exp_rd[id]   = vec_mem[base+1][11:7];
            exp_data[id] = vec_mem[base+6];
            exp_we[id]   = vec_mem[base+7][0];
            exp_err[id]  = vec_mem[base+8][0];
        end

        @(negedge clk_i);
        issue_valid_i = 1'b0;
        issue_req_i   = '0;
        if (accepted) begin
            commit_valid_i = 1'b1;
            commit_i.id    = id;
            commit_i.kill  = kill;
            @(posedge clk_i);
            if (kill) begin
                busy[id] = 1'b0;
            end
            @(negedge clk_i);
            commit_valid_i = 1'b0;
            commit_i       = '0;
        end
    endtask

    // random back-pressure and result capture
    initial begin : result_monitor
        logic [31:0] rng;
        logic        taken;
        result_t     res;
        rng            = 32'h1825;
        result_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            rng            = xorshift32(rng);
            result_ready_i = rng[0];
            #(SAMPLE_DELAY);
            taken = result_valid_o && result_ready_i;
            res   = result_o;
            @(posedge clk_i);
            if (taken && !rst_i) begin
                check_result(res);
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        @(posedge clk_i);
        while (cycles < cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_i          = 1'b1;
        issue_valid_i  = 1'b0;
        issue_req_i    = '0;
        commit_valid_i = 1'b0;
        commit_i       = '0;
        busy           = '0;
        checks         = 0;
        errors         = 0;
        results        = 0;
        busy_refusals  = 0;

        // unloaded words carry all ones in the upper half and their address below
        for (int i = 0; i < WORDS_PER * MAX_VECTORS; i++) begin
            vec_mem[i] = {16'hffff, 16'(i)};
        end
        $readmemh("verification/cpx_testdata.mem", vec_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS &&
               vec_mem[num_vectors * WORDS_PER][31:16] != 16'hffff) begin
            num_vectors++;
        end
        cycle_limit = 60 * num_vectors + 200;
        if (num_vectors == 0) begin
            errors++;
            $display("no test vectors were loaded from the data file");
        end

        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;

        for (int v = 0; v < num_vectors; v++) begin
            run_vector(v);
        end

        while (busy != '0) begin
            @(negedge clk_i);
        end
        // catch any stray result after the last expected one
        repeat (20) @(negedge clk_i);

        $display("vectors %0d, checks %0d, results %0d, busy refusals %0d, errors %0d",
                 num_vectors, checks, results, busy_refusals, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/cpx_testdata.mem */
// columns: id instr rs1 rs2 kill accept exp_data exp_we exp_err
// all hex, one vector per line
0 0020808B 00000005 00000007 0 1 0000000C 1 0
1 4020810B 00000010 00000020 0 1 FFFFFFF0 1 0
2 0020F18B F0F0F0F0 FF00FF00 0 1 F000F000 1 0
3 0020E28B 12340000 00005678 0 1 12345678 1 0
4 0020C50B AAAA5555 FFFF0000 0 1 55555555 1 0
5 00209F8B 00000003 00000024 0 1 00000030 1 0
6 0020D08B 80000000 0000001F 0 1 00000001 1 0
7 0020A10B FFFFFFFE 00000003 0 1 00000003 1 0
0 0020800B 00000001 00000002 0 1 00000003 0 0
1 0020B08B 00000001 00000002 0 1 00000000 0 1
2 0220808B 00000001 00000002 0 1 00000000 0 1
3 4020C50B 00000001 00000002 0 1 00000000 0 1
4 002080B3 00000001 00000002 0 0 00000000 0 0
4 0020808B 7FFFFFFF 00000001 0 1 80000000 1 0
5 0020808B 00000001 00000001 1 1 00000000 0 0
5 4020818B 00000000 00000001 0 1 FFFFFFFF 1 0
6 00208083 00000001 00000002 0 0 00000000 0 0
6 0020E08B 00000000 00000000 0 1 00000000 1 0
7 0020A10B 00000005 00000009 1 1 00000000 0 0
7 0020A10B 80000000 7FFFFFFF 0 1 7FFFFFFF 1 0
0 0020C08B 0F0F0F0F 0F0F0F0F 0 1 00000000 1 0
0 0020910B FFFFFFFF 00000020 0 1 FFFFFFFF 1 0
1 0020D18B F0000000 00000004 0 1 0F000000 1 0
2 0020F00B FFFFFFFF 12345678 0 1 12345678 0 0

/* sim.f */
rtl/cpx_isa_pkg.sv
rtl/cpx_bus_pkg.sv
rtl/cpx_decoder.sv
rtl/cpx_exec_unit.sv
rtl/cpx_bridge.sv
rtl/cpx_top.sv
verification/tb_clock.sv
verification/cpx_bridge_props.sv
verification/tb_cpx_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cpx_top -f sim.f -o sim_tb

output="$(./obj_dir/sim_tb 2>&1)" || true
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi
